// ==== rtl/bnn_pkg.sv ====
// ==============================
// BNN shared definitions
// ==============================

package bnn_pkg;

  // Storage limits, the top level picks the used size below these
  localparam int MAX_PIXELS  = 64;  // Width of image and weight vectors
  localparam int MAX_CLASSES = 4;   // Weight rows held

  typedef logic [7:0] spi_byte_t;   // One byte on the SPI link
  typedef logic [7:0] pixel_t;      // Grayscale pixel as sent by the host
  typedef logic [5:0] pix_addr_t;   // Pixel index within the image
  typedef logic [2:0] byte_idx_t;   // Byte index within a weight row
  typedef logic [1:0] class_t;      // Class index
  typedef logic [6:0] score_t;      // Match count, 0 to 64

  // Command bytes, first byte of every frame
  localparam spi_byte_t CMD_LOAD_W   = 8'h01;
  localparam spi_byte_t CMD_LOAD_IMG = 8'h02;
  localparam spi_byte_t CMD_READ     = 8'h03;

  localparam spi_byte_t NO_RESULT    = 8'hFF;  // Read before first inference

  // Store write request
  // A pixel write uses pix and data[0], a weight write uses cls, byte_idx and all of data
  typedef struct packed {
    logic      is_pixel;  // 1 = image bit, 0 = weight byte
    class_t    cls;
    byte_idx_t byte_idx;
    pix_addr_t pix;
    spi_byte_t data;
  } wr_req_t;

  // Inference result held by the engine
  typedef struct packed {
    logic   valid;  // Set once the first inference is done
    class_t cls;    // Winning class
    score_t score;  // Its match count
  } bnn_result_t;

endpackage

// ==== rtl/spi_byte_link.sv ====
// ==============================
// SPI mode 0 byte link
// ==============================
`timescale 1ns/1ns

module spi_byte_link (
  input  logic               clk,
  input  logic               rst,
  input  logic               sclk,
  input  logic               copi,
  input  logic               cs_n,
  input  bnn_pkg::spi_byte_t tx_byte,
  output logic               cipo,
  output logic               rx_valid,
  output logic               frame_start,
  output logic               frame_end,
  output bnn_pkg::spi_byte_t rx_byte
);
  import bnn_pkg::*;

  logic [2:0] sclk_sync;  // Two sync stages plus one for edge detect
  logic [1:0] copi_sync;  // Same depth as sclk so data lines up with the edge
  logic [2:0] cs_n_sync;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       cs_n_s;     // Synchronized chip select, low while selected
  logic [2:0] bit_cnt;    // Bits received in the current byte
  spi_byte_t  rx_shift;
  spi_byte_t  tx_shift;   // Remaining transmit bits, next one in bit 7

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_sync <= '0;
      copi_sync <= '0;
      cs_n_sync <= '1;  // Deselected out of reset
    end else begin
      sclk_sync <= {sclk_sync[1:0], sclk};
      copi_sync <= {copi_sync[0], copi};
      cs_n_sync <= {cs_n_sync[1:0], cs_n};
    end
  end

  assign sclk_rise   = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall   = ~sclk_sync[1] & sclk_sync[2];
  assign cs_n_s      = cs_n_sync[1];
  assign frame_start = ~cs_n_sync[1] & cs_n_sync[2];  // CS falling
  assign frame_end   = cs_n_sync[1] & ~cs_n_sync[2];  // CS rising

  // Receive, sample COPI on rising SCLK
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt  <= '0;
      rx_shift <= '0;
      rx_byte  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (frame_start) begin
        bit_cnt <= '0;
      end else if (sclk_rise && !cs_n_s) begin
        rx_shift <= {rx_shift[6:0], copi_sync[1]};
        bit_cnt  <= bit_cnt + 3'd1;  // Wraps to 0 after the eighth bit
        if (bit_cnt == 3'd7) begin
          rx_byte  <= {rx_shift[6:0], copi_sync[1]};
          rx_valid <= 1'b1;
        end
      end
    end
  end

  // Transmit, CIPO moves on falling SCLK, MSB first
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_shift <= '0;
      cipo     <= 1'b0;
    end else if (frame_start) begin
      tx_shift <= '0;  // Command byte goes out as zeros
      cipo     <= 1'b0;
    end else if (sclk_fall && !cs_n_s) begin
      if (bit_cnt == 3'd0) begin
        cipo     <= tx_byte[7];  // Byte boundary, fetch the next byte
        tx_shift <= {tx_byte[6:0], 1'b0};
      end else begin
        cipo     <= tx_shift[7];
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

endmodule

// ==== rtl/bnn_cmd_decoder.sv ====
// ==============================
// BNN command decoder
// ==============================
`timescale 1ns/1ns

module bnn_cmd_decoder #(
  parameter int              IMG_PIXELS  = 64,
  parameter int              NUM_CLASSES = 4,
  parameter bnn_pkg::pixel_t PIX_THRESH  = 8'd128
) (
  input  logic                 clk,
  input  logic                 rst,
  input  bnn_pkg::spi_byte_t   rx_byte,
  input  logic                 rx_valid,
  input  logic                 frame_start,
  input  logic                 frame_end,
  input  bnn_pkg::bnn_result_t result,
  output bnn_pkg::wr_req_t     wr,
  output logic                 wr_en,
  output logic                 start,
  output bnn_pkg::spi_byte_t   tx_byte
);
  import bnn_pkg::*;

  typedef enum logic [2:0] {
    CMD,       // Waiting for the command byte
    LOAD_W,    // Weight bytes, row by row
    LOAD_IMG,  // Pixel bytes
    READ,      // Class byte then score byte out
    SKIP       // Ignore everything until CS goes high
  } dec_state_t;

  localparam byte_idx_t LAST_BYTE  = byte_idx_t'(IMG_PIXELS / 8 - 1);
  localparam class_t    LAST_CLASS = class_t'(NUM_CLASSES - 1);
  localparam pix_addr_t LAST_PIX   = pix_addr_t'(IMG_PIXELS - 1);

  dec_state_t state;
  class_t     w_class;  // Weight row being loaded
  byte_idx_t  w_byte;   // Byte within that row
  pix_addr_t  pix_cnt;
  logic       rd_idx;   // 0 = class byte, 1 = score byte
  pixel_t     pix_in;
  logic       pix_bit;  // Binarized pixel

  assign pix_in  = rx_byte;
  assign pix_bit = (pix_in >= PIX_THRESH);

  // Store request straight from the received byte
  always_comb begin
    wr.is_pixel = (state == LOAD_IMG);
    wr.cls      = w_class;
    wr.byte_idx = w_byte;
    wr.pix      = pix_cnt;
    wr.data     = (state == LOAD_IMG) ? spi_byte_t'(pix_bit) : rx_byte;
  end

  assign wr_en = rx_valid && (state == LOAD_W || state == LOAD_IMG);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= CMD;
      w_class <= '0;
      w_byte  <= '0;
      pix_cnt <= '0;
      rd_idx  <= 1'b0;
      start   <= 1'b0;
    end else begin
      start <= 1'b0;
      if (frame_start || frame_end) begin
        state <= CMD;  // Every frame begins with a command
      end else if (rx_valid) begin
        case (state)
          CMD: begin
            w_class <= '0;
            w_byte  <= '0;
            pix_cnt <= '0;
            rd_idx  <= 1'b0;
            case (rx_byte)
              CMD_LOAD_W:   state <= LOAD_W;
              CMD_LOAD_IMG: state <= LOAD_IMG;
              CMD_READ:     state <= READ;
              default:      state <= SKIP;  // Unknown command
            endcase
          end
          LOAD_W: begin
            w_byte <= w_byte + byte_idx_t'(1);
            if (w_byte == LAST_BYTE) begin
              w_byte  <= '0;
              w_class <= w_class + class_t'(1);
              if (w_class == LAST_CLASS) state <= SKIP;  // All rows in
            end
          end
          LOAD_IMG: begin
            pix_cnt <= pix_cnt + pix_addr_t'(1);
            if (pix_cnt == LAST_PIX) begin
              start <= 1'b1;  // Image complete, run inference
              state <= SKIP;
            end
          end
          READ: begin
            rd_idx <= 1'b1;
            if (rd_idx) state <= SKIP;  // Both bytes sent
          end
          default: ;  // SKIP holds
        endcase
      end
    end
  end

  // Next transmit byte, picked up by the link at the byte boundary
  always_comb begin
    if (state != READ) begin
      tx_byte = '0;
    end else if (!result.valid) begin
      tx_byte = NO_RESULT;
    end else begin
      tx_byte = rd_idx ? spi_byte_t'(result.score) : spi_byte_t'(result.cls);
    end
  end

endmodule

// ==== rtl/bnn_operand_store.sv ====
// ==============================
// Image and weight store
// ==============================
`timescale 1ns/1ns

module bnn_operand_store #(
  parameter int IMG_PIXELS  = 64,
  parameter int NUM_CLASSES = 4
) (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  bnn_pkg::wr_req_t                                        wr,
  input  logic                                                    wr_en,
  output logic [bnn_pkg::MAX_PIXELS-1:0]                          image_bits,
  output logic [bnn_pkg::MAX_CLASSES-1:0][bnn_pkg::MAX_PIXELS-1:0] weight_rows
);

  logic pix_ok;  // Pixel index inside the image
  logic row_ok;  // Class and byte inside the loaded weight area

  assign pix_ok = (int'(wr.pix) < IMG_PIXELS);
  assign row_ok = (int'(wr.cls) < NUM_CLASSES) && (int'(wr.byte_idx) * 8 < IMG_PIXELS);

  // Bit p of image_bits and of each row is pixel p
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      image_bits  <= '0;
      weight_rows <= '0;
    end else if (wr_en) begin
      if (wr.is_pixel) begin
        if (pix_ok) begin
          image_bits[wr.pix] <= wr.data[0];  // Already binarized
        end
      end else if (row_ok) begin
        // First pixel of the byte sits in bit 7
        for (int k = 0; k < 8; k++) begin
          weight_rows[wr.cls][{wr.byte_idx, 3'(k)}] <= wr.data[7 - k];
        end
      end
    end
  end

endmodule

// ==== rtl/bnn_xnor_engine.sv ====
// ==============================
// XNOR popcount engine
// ==============================
`timescale 1ns/1ns

module bnn_xnor_engine #(
  parameter int IMG_PIXELS  = 64,
  parameter int NUM_CLASSES = 4
) (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  logic                                                    start,
  input  logic [bnn_pkg::MAX_PIXELS-1:0]                          image_bits,
  input  logic [bnn_pkg::MAX_CLASSES-1:0][bnn_pkg::MAX_PIXELS-1:0] weight_rows,
  output bnn_pkg::bnn_result_t                                    result,
  output logic                                                    done
);
  import bnn_pkg::*;

  typedef enum logic {
    ENG_IDLE,
    ENG_RUN
  } eng_state_t;

  localparam class_t LAST_CLASS = class_t'(NUM_CLASSES - 1);

  eng_state_t            state;
  class_t                cls_cnt;     // Class scored this cycle
  class_t                best_cls;
  score_t                best_score;
  logic [MAX_PIXELS-1:0] match;       // 1 where image and weight agree
  score_t                score;
  logic                  take;        // Current class beats the best so far
  class_t                win_cls;
  score_t                win_score;

  assign match = ~(image_bits ^ weight_rows[cls_cnt]);

  // Popcount over the used pixels only
  always_comb begin
    score = '0;
    for (int i = 0; i < IMG_PIXELS; i++) begin
      score = score + score_t'(match[i]);
    end
  end

  // Strict compare keeps the lower index on a tie
  assign take      = (cls_cnt == '0) || (score > best_score);
  assign win_cls   = take ? cls_cnt : best_cls;
  assign win_score = take ? score : best_score;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= ENG_IDLE;
      cls_cnt    <= '0;
      best_cls   <= '0;
      best_score <= '0;
      result     <= '0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ENG_IDLE: begin
          if (start) begin
            state   <= ENG_RUN;
            cls_cnt <= '0;
          end
        end
        ENG_RUN: begin  // Start is ignored here
          best_cls   <= win_cls;
          best_score <= win_score;
          cls_cnt    <= cls_cnt + class_t'(1);
          if (cls_cnt == LAST_CLASS) begin
            state  <= ENG_IDLE;
            done   <= 1'b1;
            result <= '{valid: 1'b1, cls: win_cls, score: win_score};
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/bnn_controller.sv ====
// ==============================
// BNN accelerator top
// ==============================
`timescale 1ns/1ns

module bnn_controller #(
  parameter int              IMG_PIXELS  = 64,
  parameter int              NUM_CLASSES = 4,
  parameter bnn_pkg::pixel_t PIX_THRESH  = 8'd128
) (
  input  logic clk,
  input  logic rst,
  input  logic sclk,
  input  logic copi,
  input  logic cs_n,   // Active low chip select
  output logic cipo
);
  import bnn_pkg::*;

  spi_byte_t             rx_byte;
  logic                  rx_valid;
  logic                  frame_start;
  logic                  frame_end;
  spi_byte_t             tx_byte;
  wr_req_t               wr;
  logic                  wr_en;
  logic                  start;  // Image complete
  logic                  done;
  bnn_result_t           result;
  logic [MAX_PIXELS-1:0] image_bits;
  logic [MAX_CLASSES-1:0][MAX_PIXELS-1:0] weight_rows;

  spi_byte_link spi_byte_link_i (
    .clk        (clk),
    .rst        (rst),
    .sclk       (sclk),
    .copi       (copi),
    .cs_n       (cs_n),
    .tx_byte    (tx_byte),
    .cipo       (cipo),
    .rx_valid   (rx_valid),
    .frame_start(frame_start),
    .frame_end  (frame_end),
    .rx_byte    (rx_byte)
  );

  bnn_cmd_decoder #(
    .IMG_PIXELS (IMG_PIXELS),
    .NUM_CLASSES(NUM_CLASSES),
    .PIX_THRESH (PIX_THRESH)
  ) bnn_cmd_decoder_i (
    .clk        (clk),
    .rst        (rst),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .frame_start(frame_start),
    .frame_end  (frame_end),
    .result     (result),
    .wr         (wr),
    .wr_en      (wr_en),
    .start      (start),
    .tx_byte    (tx_byte)
  );

  bnn_operand_store #(
    .IMG_PIXELS (IMG_PIXELS),
    .NUM_CLASSES(NUM_CLASSES)
  ) bnn_operand_store_i (
    .clk        (clk),
    .rst        (rst),
    .wr         (wr),
    .wr_en      (wr_en),
    .image_bits (image_bits),
    .weight_rows(weight_rows)
  );

  bnn_xnor_engine #(
    .IMG_PIXELS (IMG_PIXELS),
    .NUM_CLASSES(NUM_CLASSES)
  ) bnn_xnor_engine_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .image_bits (image_bits),
    .weight_rows(weight_rows),
    .result     (result),
    .done       (done)     // Only observed by the checkers
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
// ==============================
// Testbench clock and reset
// ==============================
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD     = 100,  // ns
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset drops just after an edge, clear of the sampling point
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #10 rst = 1'b0;
  end

endmodule

// ==== verif/bnn_assertions.sv ====
// ==============================
// BNN controller checkers
// ==============================
`timescale 1ns/1ns

module bnn_assertions #(
  parameter int NUM_CLASSES = 4
) (
  input logic clk,
  input logic rst,
  input logic cs_n,
  input logic rx_valid,
  input logic start,
  input logic done
);

  int unsigned fail_cnt = 0;  // Read by the testbench at the end
  logic [1:0]  cs_s;          // Two-flop synchronizer like the link's
  logic        pending;       // Inference started, done not yet seen

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cs_s    <= '1;
      pending <= 1'b0;
    end else begin
      cs_s <= {cs_s[0], cs_n};
      if (start) pending <= 1'b1;
      else if (done) pending <= 1'b0;
    end
  end

  // No new inference while one is running
  a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !pending)
    else begin
      $error("start pulsed while an inference was still pending");
      fail_cnt++;
    end

  // One class per cycle plus the final register stage
  a_done_after: assert property (@(posedge clk) disable iff (rst)
      start |-> ##(NUM_CLASSES + 1) done)
    else begin
      $error("done missing NUM_CLASSES + 1 cycles after start");
      fail_cnt++;
    end

  a_done_cause: assert property (@(posedge clk) disable iff (rst)
      done |-> $past(start, NUM_CLASSES + 1))
    else begin
      $error("done without a start NUM_CLASSES + 1 cycles before");
      fail_cnt++;
    end

  // cs_s[1] is the chip select the link sees in the same cycle
  a_rx_quiet: assert property (@(posedge clk) disable iff (rst) cs_s[1] |-> !rx_valid)
    else begin
      $error("rx_valid while chip select was high");
      fail_cnt++;
    end

endmodule

bind bnn_controller bnn_assertions #(
  .NUM_CLASSES(NUM_CLASSES)
) bnn_assertions_i (
  .clk     (clk),
  .rst     (rst),
  .cs_n    (cs_n),
  .rx_valid(rx_valid),
  .start   (start),
  .done    (done)
);

// ==== verif/bnn_tb.sv ====
// ==============================
// BNN controller testbench
// ==============================
`timescale 1ns/1ns

module bnn_tb;

  localparam int    IMG_PIXELS  = 64;
  localparam int    NUM_CLASSES = 4;
  localparam int    W_BYTES     = NUM_CLASSES * IMG_PIXELS / 8;  // Packed weight rows
  localparam int    HALF_SCLK   = 4;    // clk cycles per SCLK half, 800 ns period
  localparam int    DRIVE_DLY   = 10;   // ns after the rising clk edge
  // About 420 frame bytes at 64 cycles each plus gaps, near 30000 cycles
  localparam int    MAX_CYCLES  = 200000;
  localparam string TRACE_FILE  = "verif/bnn_trace.txt";

  localparam logic [7:0] LOAD_W_CMD   = 8'h01;
  localparam logic [7:0] LOAD_IMG_CMD = 8'h02;
  localparam logic [7:0] READ_CMD     = 8'h03;

  logic clk;
  logic rst;
  logic sclk;
  logic copi;
  logic cs_n;
  logic cipo;

  logic [7:0]     tx_q[$];   // Bytes after the command
  logic [7:0]     rx_q[$];   // CIPO bytes, index 0 during the command
  logic [255:0]   tok;
  logic [255:0]   test_name;
  logic [1023:0]  line;
  int             fd;
  int             rc;
  int             cycle_cnt = 0;
  int             test_cnt = 0;
  int             test_fail = 0;
  int             test_err = 0;
  int             check_cnt = 0;
  int             err_cnt = 0;

  tb_clock_gen #(.PERIOD(100), .RST_CYCLES(5)) tb_clock_gen_i (.clk(clk), .rst(rst));

  bnn_controller #(
    .IMG_PIXELS (IMG_PIXELS),
    .NUM_CLASSES(NUM_CLASSES),
    .PIX_THRESH (8'd128)
  ) bnn_controller_i (
    .clk (clk),
    .rst (rst),
    .sclk(sclk),
    .copi(copi),
    .cs_n(cs_n),
    .cipo(cipo)
  );

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Mode 0, data set while SCLK is low, both sides sample on the rise
  task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      copi = tx[i];
      wait_cycles(HALF_SCLK);
      rx[i] = cipo;
      sclk  = 1'b1;
      wait_cycles(HALF_SCLK);
      sclk  = 1'b0;
    end
  endtask

  task automatic run_frame(input logic [7:0] cmd);
    logic [7:0] r;
    rx_q.delete();
    wait_cycles(1);
    cs_n = 1'b0;
    wait_cycles(HALF_SCLK);  // Let the link see the frame start
    xfer_byte(cmd, r);
    rx_q.push_back(r);
    foreach (tx_q[k]) begin
      xfer_byte(tx_q[k], r);
      rx_q.push_back(r);
    end
    wait_cycles(HALF_SCLK);
    cs_n = 1'b1;
    copi = 1'b0;
    wait_cycles(2 * HALF_SCLK);  // Gap between frames
  endtask

  task automatic read_bytes(input int n);
    logic [7:0] b;
    tx_q.delete();
    for (int k = 0; k < n; k++) begin
      if ($fscanf(fd, "%h", b) != 1) begin
        $display("Trace ended inside a byte list of %0d bytes", n);
        err_cnt++;
        test_err++;
        break;
      end
      tx_q.push_back(b);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    check_cnt++;
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %02h, got %02h", $time, name, exp, act);
      err_cnt++;
      test_err++;
    end
  endtask

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    int         n;
    logic [7:0] exp_cls;
    logic [7:0] exp_score;
    cs_n = 1'b1;  // Idle bus
    sclk = 1'b0;
    copi = 1'b0;
    wait (rst === 1'b0);
    wait_cycles(4);
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the trace file %s", TRACE_FILE);
      err_cnt++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          rc = $fgets(line, fd);  // Skip the comment text
        end else if (tok == "test") begin
          rc = $fscanf(fd, "%s", test_name);
          test_err = 0;
        end else if (tok == "W") begin
          read_bytes(W_BYTES);
          run_frame(LOAD_W_CMD);
        end else if (tok == "I") begin
          read_bytes(IMG_PIXELS);
          run_frame(LOAD_IMG_CMD);
        end else if (tok == "A") begin
          rc = $fscanf(fd, "%d", n);  // Pixels sent before CS rises
          if (rc != 1) begin
            $display("Trace holds no pixel count after A");
            err_cnt++;
            test_err++;
          end
          read_bytes(n);
          run_frame(LOAD_IMG_CMD);
        end else if (tok == "R") begin
          rc = $fscanf(fd, "%h %h", exp_cls, exp_score);
          if (rc != 2) begin
            $display("Trace holds no expected bytes after R");
            err_cnt++;
            test_err++;
          end
          tx_q = '{8'h00, 8'h00};
          run_frame(READ_CMD);
          check_byte("cipo class byte", exp_cls, rx_q[1]);
          check_byte("cipo score byte", exp_score, rx_q[2]);
        end else if (tok == "end") begin
          test_cnt++;
          if (test_err != 0) begin
            test_fail++;
            $display("Test %0s failed with %0d errors", test_name, test_err);
          end else begin
            $display("Test %0s passed", test_name);
          end
        end else begin
          $display("Unknown token in the trace: %0s", tok);
          err_cnt++;
        end
      end
      $fclose(fd);
    end
    if (test_cnt == 0) begin
      $display("No test was found in the trace");
      err_cnt++;
    end
    if (bnn_controller_i.bnn_assertions_i.fail_cnt != 0) begin
      $display("%0d assertion failures were reported",
               bnn_controller_i.bnn_assertions_i.fail_cnt);
      err_cnt += int'(bnn_controller_i.bnn_assertions_i.fail_cnt);
    end
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, test_fail, check_cnt, err_cnt);
    if (err_cnt == 0 && test_fail == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== verif/bnn_trace.txt ====
# Tokens: test <name>, W <32 weight bytes>, I <64 pixel bytes>, A <count> <pixel bytes>,
# R <expected class byte> <expected score byte>, end. Bytes in hex, the count in decimal.
test reset_read
R ff ff
end
test basic
W ff ff ff ff ff ff ff ff 00 00 00 00 00 00 00 00 ff ff ff ff 00 00 00 00 f0 f0 f0 f0 f0 f0 f0 f0
I c8 ff 80 a0 e1 90 b7 d0 ff 81 c0 f2 99 ab 80 de 88 ff c4 a5 b0 e8 fe 93 80 cc 9f ba d7 ff 85 f0
  00 10 7f 3c 05 60 7e 21 00 44 12 7f 33 08 59 6a 01 7f 20 4d 00 1f 66 0e 7f 00 2a 55 71 00 3b 7f
R 02 40
end
test tie
I ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00
  00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
R 01 30
end
test thresh_low
I 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f
  7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f
R 01 40
end
test thresh_high
I 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
  80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
R 00 40
end
test abort
A 20 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
R 00 40
I ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00
  ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00
R 03 40
end

// ==== project.f ====
rtl/bnn_pkg.sv
rtl/spi_byte_link.sv
rtl/bnn_cmd_decoder.sv
rtl/bnn_operand_store.sv
rtl/bnn_xnor_engine.sv
rtl/bnn_controller.sv
verif/tb_clock_gen.sv
verif/bnn_assertions.sv
verif/bnn_tb.sv

// ==== Makefile ====
# Verilator flow for the BNN controller
TOP := bnn_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

# The run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qx "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
